/* rtl/rx_intf_params.svh */
// rx interface parameters
`ifndef RX_INTF_PARAMS_SVH
`define RX_INTF_PARAMS_SVH

// stream word and decoder byte
`define RX_WORD_WIDTH      64
`define RX_BYTE_WIDTH      8
`define RX_BYTES_PER_WORD  8

// word buffer
`define RX_FIFO_DEPTH      16
`define RX_FIFO_ADDR_WIDTH 4
// room kept for a data word in flight, the flush word and the trailer
`define RX_FIFO_RESERVE    3

// trailer field positions
`define RX_TRL_FCS_BIT     0
`define RX_TRL_OVF_BIT     1
`define RX_TRL_SN_LSB      16
`define RX_TRL_CNT_LSB     32

`endif

/* rtl/rx_intf_pkg.sv */
// rx interface types
`include "rx_intf_params.svh"

package rx_intf_pkg;

  // one stream word
  typedef logic [`RX_WORD_WIDTH-1:0] rx_word_t;

  // one decoder byte
  typedef logic [`RX_BYTE_WIDTH-1:0] rx_byte_t;

  // packet serial number
  typedef logic [15:0] rx_sn_t;

  // received byte count
  typedef logic [15:0] rx_len_t;

  // producer states
  typedef enum logic [1:0] {
    PACK_IDLE,
    PACK_COLLECT,
    PACK_FLUSH,
    PACK_TRAILER
  } rx_pack_state_t;

endpackage

/* rtl/rx_intf_ifs.sv */
// rx word interfaces
`timescale 1ns/1ps

// producer to buffer
interface rx_word_wr_if;
  import rx_intf_pkg::*;

  rx_word_t word;
  logic     word_strobe;
  logic     word_last;
  logic     fulln;

  modport src (output word, output word_strobe, output word_last, input fulln);
  modport snk (input word, input word_strobe, input word_last, output fulln);
endinterface

// buffer to consumer, show-ahead
interface rx_word_rd_if;
  import rx_intf_pkg::*;

  rx_word_t word;
  logic     word_last;
  logic     emptyn;
  logic     rd_en;

  modport src (output word, output word_last, output emptyn, input rd_en);
  modport snk (input word, input word_last, input emptyn, output rd_en);
endinterface

/* rtl/rx_byte_packer.sv */
// rx byte packer
`timescale 1ns/1ps
`include "rx_intf_params.svh"

module rx_byte_packer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pkt_header_valid,
  input  logic                  pkt_header_valid_strobe,
  input  logic                  byte_in_strobe,
  input  logic                  fcs_in_strobe,
  input  logic                  fcs_ok,
  input  rx_intf_pkg::rx_byte_t byte_in,
  rx_word_wr_if.src             wr
);
  import rx_intf_pkg::*;

  localparam int LANE_W = $clog2(`RX_BYTES_PER_WORD);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`RX_BYTES_PER_WORD - 1);

  rx_pack_state_t    state;
  rx_word_t          acc;
  rx_word_t          acc_next;
  logic [LANE_W-1:0] lane;
  rx_len_t           byte_cnt;
  rx_sn_t            sn;
  logic              fcs_ok_q;
  logic              ovf;
  logic              pkt_start;

  assign pkt_start = pkt_header_valid_strobe & pkt_header_valid;

  function automatic rx_word_t make_trailer(input logic fcs, input logic ovf_flag,
                                            input rx_sn_t sn_val, input rx_len_t cnt);
    rx_word_t t;
    t = '0;
    t[`RX_TRL_FCS_BIT] = fcs;
    t[`RX_TRL_OVF_BIT] = ovf_flag;
    t[`RX_TRL_SN_LSB +: $bits(rx_sn_t)] = sn_val;
    t[`RX_TRL_CNT_LSB +: $bits(rx_len_t)] = cnt;
    return t;
  endfunction

  // current byte dropped into its lane
  always_comb
  begin
    acc_next = acc;
    acc_next[lane*`RX_BYTE_WIDTH +: `RX_BYTE_WIDTH] = byte_in;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state          <= PACK_IDLE;
      wr.word_strobe <= 1'b0;
      wr.word_last   <= 1'b0;
      lane           <= '0;
      byte_cnt       <= '0;
      sn             <= '0;
      ovf            <= 1'b0;
      fcs_ok_q       <= 1'b0;
    end
    else
    begin
      wr.word_strobe <= 1'b0;
      wr.word_last   <= 1'b0;
      case (state)
        PACK_IDLE, PACK_COLLECT:
        begin
          if (pkt_start)
          begin
            state    <= PACK_COLLECT;
            acc      <= '0;
            lane     <= '0;
            byte_cnt <= '0;
            ovf      <= 1'b0;
          end
          else if (state == PACK_COLLECT && fcs_in_strobe)
          begin
            fcs_ok_q       <= fcs_ok;
            wr.word_strobe <= 1'b1;
            if (lane != '0)
            begin
              // upper lanes of acc are still zero
              wr.word <= acc;
              state   <= PACK_FLUSH;
            end
            else
            begin
              wr.word      <= make_trailer(fcs_ok, ovf, sn, byte_cnt);
              wr.word_last <= 1'b1;
              state        <= PACK_TRAILER;
            end
          end
          else if (state == PACK_COLLECT && byte_in_strobe)
          begin
            byte_cnt <= byte_cnt + 1'b1;
            lane     <= lane + 1'b1;
            if (lane == LAST_LANE)
            begin
              // full word, dropped when the buffer is short of room
              wr.word        <= acc_next;
              wr.word_strobe <= wr.fulln;
              ovf            <= ovf | ~wr.fulln;
              acc            <= '0;
            end
            else
            begin
              acc <= acc_next;
            end
          end
        end
        PACK_FLUSH:
        begin
          wr.word        <= make_trailer(fcs_ok_q, ovf, sn, byte_cnt);
          wr.word_strobe <= 1'b1;
          wr.word_last   <= 1'b1;
          state          <= PACK_TRAILER;
        end
        PACK_TRAILER:
        begin
          // trailer is on the bus this cycle
          sn    <= sn + 1'b1;
          state <= PACK_IDLE;
        end
        default:
        begin
          state <= PACK_IDLE;
        end
      endcase
    end
  end

endmodule

/* rtl/rx_word_fifo.sv */
// rx word buffer
`timescale 1ns/1ps
`include "rx_intf_params.svh"

module rx_word_fifo (
  input  logic      clk,
  input  logic      rst,
  rx_word_wr_if.snk wr,
  rx_word_rd_if.src rd
);
  import rx_intf_pkg::*;

  localparam int AW = `RX_FIFO_ADDR_WIDTH;
  localparam int CW = AW + 1;
  localparam logic [CW-1:0] DEPTH = CW'(`RX_FIFO_DEPTH);
  // fulln drops once only the reserve is left
  localparam logic [CW-1:0] FULLN_LIMIT = CW'(`RX_FIFO_DEPTH - `RX_FIFO_RESERVE);

  rx_word_t      mem_word [`RX_FIFO_DEPTH];
  logic          mem_last [`RX_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign push = wr.word_strobe && (count != DEPTH);
  assign pop  = rd.rd_en && rd.emptyn;

  assign rd.emptyn = (count != '0);
  assign wr.fulln  = (count < FULLN_LIMIT);

  // head entry shown ahead of the pop
  assign rd.word      = mem_word[rd_ptr];
  assign rd.word_last = mem_last[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_word[wr_ptr] <= wr.word;
      mem_last[wr_ptr] <= wr.word_last;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/rx_stream_out.sv */
// rx stream output stage
`timescale 1ns/1ps

module rx_stream_out (
  input  logic                  clk,
  input  logic                  rst,
  rx_word_rd_if.snk             rd,
  input  logic                  m00_axis_tready,
  output logic                  m00_axis_tvalid,
  output logic                  m00_axis_tlast,
  output logic                  rx_pkt_intr,
  output rx_intf_pkg::rx_word_t m00_axis_tdata
);

  logic load;
  logic last_accept;

  // refill when the register is empty or drains this cycle
  assign load = rd.emptyn && (!m00_axis_tvalid || m00_axis_tready);

  // pop the head in the same cycle it is loaded
  assign rd.rd_en = load;

  // end of packet handshake
  assign last_accept = m00_axis_tvalid && m00_axis_tready && m00_axis_tlast;

  // output word and its last flag
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      m00_axis_tdata <= rd.word;
      m00_axis_tlast <= rd.word_last;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      m00_axis_tvalid <= 1'b0;
    end
    else if (load)
    begin
      m00_axis_tvalid <= 1'b1;
    end
    else if (m00_axis_tready)
    begin
      // accepted with nothing behind it
      m00_axis_tvalid <= 1'b0;
    end
  end

  // one pulse per packet, the cycle after the trailer leaves
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_pkt_intr <= 1'b0;
    end
    else
    begin
      rx_pkt_intr <= last_accept;
    end
  end

endmodule

/* rtl/rx_intf.sv */
// rx interface top
`timescale 1ns/1ps

module rx_intf (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pkt_header_valid,
  input  logic                  pkt_header_valid_strobe,
  input  rx_intf_pkg::rx_byte_t byte_in,
  input  logic                  byte_in_strobe,
  input  logic                  fcs_in_strobe,
  input  logic                  fcs_ok,
  input  logic                  m00_axis_tready,
  output logic                  m00_axis_tvalid,
  output rx_intf_pkg::rx_word_t m00_axis_tdata,
  output logic                  m00_axis_tlast,
  output logic                  rx_pkt_intr
);

  rx_word_wr_if wr_if ();
  rx_word_rd_if rd_if ();

  // decoder bytes to words and trailer
  rx_byte_packer packer_i (
    .clk                     (clk),
    .rst                     (rst),
    .pkt_header_valid        (pkt_header_valid),
    .pkt_header_valid_strobe (pkt_header_valid_strobe),
    .byte_in_strobe          (byte_in_strobe),
    .fcs_in_strobe           (fcs_in_strobe),
    .fcs_ok                  (fcs_ok),
    .byte_in                 (byte_in),
    .wr                      (wr_if.src)
  );

  rx_word_fifo fifo_i (
    .clk (clk),
    .rst (rst),
    .wr  (wr_if.snk),
    .rd  (rd_if.src)
  );

  // stream toward the dma
  rx_stream_out stream_i (
    .clk             (clk),
    .rst             (rst),
    .rd              (rd_if.snk),
    .m00_axis_tready (m00_axis_tready),
    .m00_axis_tvalid (m00_axis_tvalid),
    .m00_axis_tlast  (m00_axis_tlast),
    .rx_pkt_intr     (rx_pkt_intr),
    .m00_axis_tdata  (m00_axis_tdata)
  );

endmodule

/* sim/rx_intf_asserts.sv */
// rx stream protocol assertions
`timescale 1ns/1ps

module rx_intf_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  m00_axis_tvalid,
  input logic                  m00_axis_tready,
  input logic                  m00_axis_tlast,
  input logic                  rx_pkt_intr,
  input rx_intf_pkg::rx_word_t m00_axis_tdata
);

  logic stalled;
  logic last_hs;

  assign stalled = m00_axis_tvalid && !m00_axis_tready;
  assign last_hs = m00_axis_tvalid && m00_axis_tready && m00_axis_tlast;

  // word waits for its handshake
  valid_held: assert property (@(posedge clk) disable iff (rst) stalled |=> m00_axis_tvalid)
    else $error("tvalid dropped before the word was accepted");

  data_stable: assert property (@(posedge clk) disable iff (rst)
    stalled |=> ($stable(m00_axis_tdata) && $stable(m00_axis_tlast)))
    else $error("tdata or tlast changed while stalled");

  intr_after_last: assert property (@(posedge clk) disable iff (rst) last_hs |=> rx_pkt_intr)
    else $error("no interrupt after the tlast handshake");

  // no pulse without a preceding trailer handshake
  intr_only_after_last: assert property (@(posedge clk) disable iff (rst)
    rx_pkt_intr |-> $past(last_hs))
    else $error("interrupt without a tlast handshake");

endmodule

bind rx_stream_out rx_intf_asserts asserts_i (
  .clk             (clk),
  .rst             (rst),
  .m00_axis_tvalid (m00_axis_tvalid),
  .m00_axis_tready (m00_axis_tready),
  .m00_axis_tlast  (m00_axis_tlast),
  .rx_pkt_intr     (rx_pkt_intr),
  .m00_axis_tdata  (m00_axis_tdata)
);

/* sim/rx_intf_tb.sv */
// rx interface testbench
`timescale 1ns/1ps
`include "rx_intf_params.svh"

module rx_intf_tb;
  import rx_intf_pkg::*;

  logic clk = 1'b0;
  logic rst;
  logic pkt_header_valid;
  logic pkt_header_valid_strobe;
  rx_byte_t byte_in;
  logic byte_in_strobe;
  logic fcs_in_strobe;
  logic fcs_ok;
  logic m00_axis_tready;
  logic m00_axis_tvalid;
  rx_word_t m00_axis_tdata;
  logic m00_axis_tlast;
  logic rx_pkt_intr;

  // each entry is {tlast, tdata}
  logic [`RX_WORD_WIDTH:0] got_q[$];
  logic [`RX_WORD_WIDTH:0] exp_q[$];
  rx_byte_t pkt_bytes[$];
  logic ready_pat[1024];
  int ready_mode = 1;
  int cyc = 0;
  int errors = 0;
  int last_count = 0;
  int intr_count = 0;
  logic last_hs = 1'b0;
  rx_sn_t exp_sn = '0;

  rx_intf dut_i (.*);

  always #5 clk = ~clk;

  // tready is low in mode 0, high in mode 1 and random in mode 2
  always @(posedge clk)
  begin
    if (ready_mode == 2)
      m00_axis_tready <= ready_pat[cyc % 1024];
    else
      m00_axis_tready <= (ready_mode == 1);
    cyc <= cyc + 1;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  // accepted words and interrupt timing
  always @(posedge clk)
  begin
    if (rst)
    begin
      last_hs = 1'b0;
    end
    else
    begin
      check("rx_pkt_intr", rx_pkt_intr, last_hs);
      if (rx_pkt_intr)
        intr_count++;
      if (m00_axis_tvalid && m00_axis_tready)
      begin
        got_q.push_back({m00_axis_tlast, m00_axis_tdata});
        if (m00_axis_tlast)
          last_count++;
      end
      last_hs = m00_axis_tvalid && m00_axis_tready && m00_axis_tlast;
    end
  end

  task automatic drive_cycle(input logic hs, input logic hv, input logic bs, input logic fs,
                             input logic ok, input rx_byte_t b);
    @(posedge clk);
    pkt_header_valid_strobe <= hs;
    pkt_header_valid        <= hv;
    byte_in_strobe          <= bs;
    fcs_in_strobe           <= fs;
    fcs_ok                  <= ok;
    byte_in                 <= b;
  endtask

  // expected words from the packing rules
  task automatic model_packet(input logic fcs, input logic ovf);
    rx_word_t w;
    int n;
    w = '0;
    n = pkt_bytes.size();
    for (int k = 0; k < n; k++)
    begin
      w[`RX_BYTE_WIDTH*(k % `RX_BYTES_PER_WORD) +: `RX_BYTE_WIDTH] = pkt_bytes[k];
      if (k % `RX_BYTES_PER_WORD == `RX_BYTES_PER_WORD - 1)
      begin
        exp_q.push_back({1'b0, w});
        w = '0;
      end
    end
    if (n % `RX_BYTES_PER_WORD != 0)
      exp_q.push_back({1'b0, w});
    w = '0;
    w[`RX_TRL_FCS_BIT] = fcs;
    w[`RX_TRL_OVF_BIT] = ovf;
    w[`RX_TRL_SN_LSB +: 16] = exp_sn;
    w[`RX_TRL_CNT_LSB +: 16] = n[15:0];
    exp_q.push_back({1'b1, w});
    exp_sn++;
  endtask

  task automatic send_packet(input int len, input logic fcs, input logic ovf);
    rx_byte_t b;
    pkt_bytes.delete();
    drive_cycle(1, 1, 0, 0, 0, 0);
    for (int k = 0; k < len; k++)
    begin
      b = rx_byte_t'($urandom);
      pkt_bytes.push_back(b);
      drive_cycle(0, 0, 1, 0, 0, b);
    end
    drive_cycle(0, 0, 0, 1, fcs, 0);
    repeat (4) drive_cycle(0, 0, 0, 0, 0, 0);
    model_packet(fcs, ovf);
  endtask

  task automatic wait_packets(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (last_count < target && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (last_count < target)
    begin
      $display("timeout waiting for packet %0d on the stream", target);
      errors++;
    end
    // catch any extra words
    repeat (6) @(posedge clk);
  endtask

  task automatic compare_words();
    check("word_count", got_q.size(), exp_q.size());
    while (got_q.size() > 0 && exp_q.size() > 0)
    begin
      check("m00_axis_tdata", got_q[0][63:0], exp_q[0][63:0]);
      check("m00_axis_tlast", got_q[0][64], exp_q[0][64]);
      void'(got_q.pop_front());
      void'(exp_q.pop_front());
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // data words before the flush word are a prefix of the model
  task automatic compare_overflow();
    int n;
    int m;
    n = got_q.size();
    m = exp_q.size();
    if (n < 2 || n >= m)
    begin
      $display("overflow packet came out with %0d words, model has %0d", n, m);
      errors++;
    end
    else
    begin
      for (int i = 0; i < n - 2; i++)
      begin
        check("m00_axis_tdata", got_q[i][63:0], exp_q[i][63:0]);
        check("m00_axis_tlast", got_q[i][64], 1'b0);
      end
      check("m00_axis_tdata", got_q[n-2][63:0], exp_q[m-2][63:0]);
      check("m00_axis_tlast", got_q[n-2][64], 1'b0);
      check("m00_axis_tdata", got_q[n-1][63:0], exp_q[m-1][63:0]);
      check("m00_axis_tlast", got_q[n-1][64], 1'b1);
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic report(input int id, input string name, input int err_start);
    $display("test %0d %s: %s", id, name, (errors == err_start) ? "pass" : "FAIL");
  endtask

  initial
  begin
    int e0;
    int i0;
    void'($urandom(79));
    for (int i = 0; i < 1024; i++)
      ready_pat[i] = $urandom % 2;
    rst = 1'b1;
    pkt_header_valid = 1'b0;
    pkt_header_valid_strobe = 1'b0;
    byte_in = '0;
    byte_in_strobe = 1'b0;
    fcs_in_strobe = 1'b0;
    fcs_ok = 1'b0;
    m00_axis_tready = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check("m00_axis_tvalid", m00_axis_tvalid, 1'b0);

    e0 = errors;
    i0 = intr_count;
    send_packet(16, 1'b1, 1'b0);
    wait_packets(1, 200);
    compare_words();
    check("intr_count", intr_count - i0, 1);
    report(1, "aligned packet", e0);

    e0 = errors;
    send_packet(11, 1'b0, 1'b0);
    wait_packets(2, 200);
    compare_words();
    report(2, "partial word", e0);

    e0 = errors;
    drive_cycle(1, 0, 0, 0, 0, 0);
    drive_cycle(0, 0, 1, 0, 0, 8'h5a);
    drive_cycle(0, 0, 1, 0, 0, 8'ha5);
    drive_cycle(0, 0, 0, 1, 1, 0);
    repeat (20) drive_cycle(0, 0, 0, 0, 0, 0);
    check("stray_words", got_q.size(), 0);
    send_packet(9, 1'b1, 1'b0);
    wait_packets(3, 200);
    compare_words();
    report(3, "ignored input", e0);

    e0 = errors;
    ready_mode <= 2;
    for (int p = 0; p < 5; p++)
      send_packet(1 + $urandom % 40, $urandom % 2, 1'b0);
    wait_packets(8, 2000);
    compare_words();
    report(4, "random back-pressure", e0);

    e0 = errors;
    i0 = intr_count;
    ready_mode <= 0;
    repeat (4) @(posedge clk);
    send_packet(165, 1'b1, 1'b1);
    repeat (10) @(posedge clk);
    ready_mode <= 1;
    wait_packets(9, 500);
    compare_overflow();
    check("intr_count", intr_count - i0, 1);
    report(5, "overflow", e0);

    $display("tests run 5, mismatches %0d", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+rtl
rtl/rx_intf_pkg.sv
rtl/rx_intf_ifs.sv
rtl/rx_byte_packer.sv
rtl/rx_word_fifo.sv
rtl/rx_stream_out.sv
rtl/rx_intf.sv
sim/rx_intf_asserts.sv
sim/rx_intf_tb.sv
